//--- tsc_control.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/state_sequencer.sv
hdl/control_signal_gen.sv
hdl/control_unit.sv
bench/control_unit_asserts.sv
bench/control_unit_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module control_unit_tb \
  -Mdir obj_dir \
  -f tsc_control.f

./obj_dir/Vcontrol_unit_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- bench/control_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module control_unit_tb;

  localparam int CLK_PERIOD     = 8;
  localparam int DIRECTED_COUNT = 16;
  localparam int RANDOM_COUNT   = 400;
  localparam int TIMEOUT_NS     = (DIRECTED_COUNT + RANDOM_COUNT) * 5 * CLK_PERIOD + 500;

  // legal function codes for a 4-bit draw
  localparam logic [`FUNC_W-1:0] FUNCS [12] = '{
    isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::ORR,
    isa_pkg::NOT, isa_pkg::TCP, isa_pkg::SHL, isa_pkg::SHR,
    isa_pkg::JPR, isa_pkg::JRL, isa_pkg::WWD, isa_pkg::HLT
  };

  logic                 clk;
  logic                 reset_n;
  logic [`OPCODE_W-1:0] opcode;
  logic [`FUNC_W-1:0]   func_code;
  logic                 mem_write;
  logic                 mem_read;
  logic                 reg_write;
  logic                 reg_dst;
  logic                 pc_to_reg;
  logic                 mem_to_reg;
  logic                 alu_src_a;
  logic                 alu_src_b;
  logic                 alu_op;
  logic                 pc_store;
  logic                 branch_dst_store;
  logic                 branch;
  logic                 jal;
  logic                 jalr;
  logic                 pc_update;
  logic                 halt;
  logic                 wwd;

  logic [15:0]          lfsr;
  ctrl_pkg::fsm_state_e model_state;
  string                test_name = "reset";

  control_unit dut (.*);

  bind control_unit control_unit_asserts u_asserts (
    .clk       (clk),
    .reset_n   (reset_n),
    .state     (state),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .pc_update (pc_update),
    .halt      (halt),
    .reg_write (reg_write)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  function automatic ctrl_pkg::instr_class_e classify(input logic [`OPCODE_W-1:0] op,
                                                       input logic [`FUNC_W-1:0]   fn);
    case (op)
      isa_pkg::BNE, isa_pkg::BEQ, isa_pkg::BGZ, isa_pkg::BLZ: return ctrl_pkg::C_BRANCH;
      isa_pkg::ADI, isa_pkg::ORI, isa_pkg::LHI:               return ctrl_pkg::C_ALU_I;
      isa_pkg::LWD: return ctrl_pkg::C_LOAD;
      isa_pkg::SWD: return ctrl_pkg::C_STORE;
      isa_pkg::JMP: return ctrl_pkg::C_JMP;
      isa_pkg::JAL: return ctrl_pkg::C_JAL;
      isa_pkg::ALU: begin
        if (fn <= isa_pkg::SHR) return ctrl_pkg::C_ALU_R;
        case (fn)
          isa_pkg::JPR: return ctrl_pkg::C_JPR;
          isa_pkg::JRL: return ctrl_pkg::C_JRL;
          isa_pkg::WWD: return ctrl_pkg::C_WWD;
          isa_pkg::HLT: return ctrl_pkg::C_HALT;
          default:      return ctrl_pkg::C_ILLEGAL;
        endcase
      end
      default: return ctrl_pkg::C_ILLEGAL;
    endcase
  endfunction

  function automatic int path_len(input ctrl_pkg::instr_class_e c);
    case (c)
      ctrl_pkg::C_LOAD:                    return 5;
      ctrl_pkg::C_ALU_R, ctrl_pkg::C_ALU_I,
      ctrl_pkg::C_STORE, ctrl_pkg::C_BRANCH: return 4;
      ctrl_pkg::C_HALT, ctrl_pkg::C_ILLEGAL: return 0;
      default:                             return 3;
    endcase
  endfunction

  function automatic ctrl_pkg::fsm_state_e next_state_of(input ctrl_pkg::instr_class_e c,
                                                          input ctrl_pkg::fsm_state_e s);
    case (s)
      ctrl_pkg::S_IF:
        return (c inside {ctrl_pkg::C_HALT, ctrl_pkg::C_ILLEGAL}) ? ctrl_pkg::S_IF
                                                                  : ctrl_pkg::S_ID;
      ctrl_pkg::S_ID:
        return (c inside {ctrl_pkg::C_JAL, ctrl_pkg::C_JRL}) ? ctrl_pkg::S_WB : ctrl_pkg::S_EX1;
      ctrl_pkg::S_EX1: begin
        if (c inside {ctrl_pkg::C_ALU_R, ctrl_pkg::C_ALU_I}) return ctrl_pkg::S_WB;
        if (c inside {ctrl_pkg::C_LOAD, ctrl_pkg::C_STORE}) return ctrl_pkg::S_MEM;
        if (c == ctrl_pkg::C_BRANCH) return ctrl_pkg::S_EX2;
        return ctrl_pkg::S_IF;
      end
      ctrl_pkg::S_MEM: return (c == ctrl_pkg::C_LOAD) ? ctrl_pkg::S_WB : ctrl_pkg::S_IF;
      default:         return ctrl_pkg::S_IF;
    endcase
  endfunction

  // expected control word in the compare's bit order
  function automatic logic [16:0] expected_word(input ctrl_pkg::instr_class_e c,
                                                input ctrl_pkg::fsm_state_e   s);
    logic id;
    logic ex1;
    logic ex2;
    logic mem;
    logic wb;
    logic past;
    logic is_alu;
    logic is_ld;
    logic is_st;
    logic is_br;
    logic src_a;
    logic src_b;
    logic op;
    id     = (s == ctrl_pkg::S_ID);
    ex1    = (s == ctrl_pkg::S_EX1);
    ex2    = (s == ctrl_pkg::S_EX2);
    mem    = (s == ctrl_pkg::S_MEM);
    wb     = (s == ctrl_pkg::S_WB);
    past   = (s != ctrl_pkg::S_IF);
    is_alu = c inside {ctrl_pkg::C_ALU_R, ctrl_pkg::C_ALU_I};
    is_ld  = (c == ctrl_pkg::C_LOAD);
    is_st  = (c == ctrl_pkg::C_STORE);
    is_br  = (c == ctrl_pkg::C_BRANCH);
    src_a  = ((is_alu || is_st) && (ex1 || mem || wb)) || (is_ld && (ex1 || mem))
             || (is_br && (ex1 || ex2));
    src_b  = src_a && (c != ctrl_pkg::C_ALU_R) && !ex2;
    op     = ((is_alu || is_ld || is_st) && (ex1 || mem || wb)) || (is_br && ex2)
             || (c == ctrl_pkg::C_JMP && ex1);
    return {mem && is_st,
            mem && is_ld,
            wb,
            wb && (c == ctrl_pkg::C_ALU_I || is_ld),
            wb && (c == ctrl_pkg::C_JRL),
            wb && is_ld,
            src_a,
            src_b,
            op,
            id && !(c inside {ctrl_pkg::C_JMP, ctrl_pkg::C_JAL, ctrl_pkg::C_JPR}),
            ex1 && is_br,
            is_br && (id || ex1 || ex2),
            past && (c inside {ctrl_pkg::C_JMP, ctrl_pkg::C_JAL}),
            past && (c inside {ctrl_pkg::C_JPR, ctrl_pkg::C_JRL}),
            past && (next_state_of(c, s) == ctrl_pkg::S_IF), // last state of path
            c == ctrl_pkg::C_HALT,
            past && (c == ctrl_pkg::C_WWD)};
  endfunction

  // runs from a falling edge to the falling edge in the next IF
  task automatic issue(input logic [`OPCODE_W-1:0] op, input logic [`FUNC_W-1:0] fn,
                       input string name);
    ctrl_pkg::instr_class_e c;
    logic [15:0]            hold;
    int                     cycles;
    opcode    = op;
    func_code = fn;
    test_name = name;
    c         = classify(op, fn);
    if (c inside {ctrl_pkg::C_HALT, ctrl_pkg::C_ILLEGAL}) begin
      draw_bits(2, hold);
      repeat (hold % 3 + 1) @(negedge clk);
    end else begin
      cycles = 1;
      do begin
        @(negedge clk);
        cycles++;
        assert (cycles <= 8) else begin
          $display("%s: pc_update never came after %0d cycles", name, cycles);
          $display("STATUS: FAIL");
          $fatal(1, "instruction did not end");
        end
      end while (!pc_update);
      assert (cycles == path_len(c)) else begin
        $display("ERROR %s cycles: expected %0d, actual %0d", name, path_len(c), cycles);
        $display("STATUS: FAIL");
        $fatal(1, "wrong instruction length");
      end
      @(negedge clk);
    end
  endtask

  task automatic pick_random(output logic [`OPCODE_W-1:0] op, output logic [`FUNC_W-1:0] fn);
    logic [15:0] r;
    logic [15:0] k;
    draw_bits(4, r);
    op = isa_pkg::ALU;
    fn = isa_pkg::ADD;
    if (r < 11) begin
      op = r[3:0];
    end else if (r == 14) begin
      draw_bits(2, k);
      op = 4'd11 + {2'b00, k[1:0]}; // unused opcodes
    end else if (r != 15) begin
      draw_bits(4, k);
      fn = (k < 12) ? FUNCS[k[3:0]] : 6'd8 + {2'b00, k[3:0]}; // 20..23 unused
    end
  endtask

  always @(posedge clk) begin
    logic [16:0] exp_w;
    logic [16:0] act_w;
    if (reset_n) begin
      model_state = ctrl_pkg::S_IF;
    end else begin
      exp_w = expected_word(classify(opcode, func_code), model_state);
      act_w = {mem_write, mem_read, reg_write, reg_dst, pc_to_reg, mem_to_reg,
               alu_src_a, alu_src_b, alu_op, pc_store, branch_dst_store, branch,
               jal, jalr, pc_update, halt, wwd};
      assert (act_w == exp_w) else begin
        $display("ERROR %s in %s: expected %b, actual %b",
                 test_name, model_state.name(), exp_w, act_w);
        $display("STATUS: FAIL");
        $fatal(1, "control word mismatch");
      end
      model_state = next_state_of(classify(opcode, func_code), model_state);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run did not finish within %0d ns", TIMEOUT_NS);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [`OPCODE_W-1:0] op;
    logic [`FUNC_W-1:0]   fn;
    reset_n   = 1'b1;
    opcode    = isa_pkg::ALU;
    func_code = isa_pkg::ADD;
    lfsr      = 16'd57847;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b0;
    issue(isa_pkg::ALU, isa_pkg::ADD, "reset_then_add");
    issue(isa_pkg::ADI, 6'd0, "alu_imm");
    issue(isa_pkg::LWD, 6'd0, "load");
    issue(isa_pkg::SWD, 6'd0, "store");
    issue(isa_pkg::BNE, 6'd0, "branch_bne");
    issue(isa_pkg::BEQ, 6'd0, "branch_beq");
    issue(isa_pkg::BGZ, 6'd0, "branch_bgz");
    issue(isa_pkg::BLZ, 6'd0, "branch_blz");
    issue(isa_pkg::JMP, 6'd0, "jump");
    issue(isa_pkg::JAL, 6'd0, "jump_link");
    issue(isa_pkg::ALU, isa_pkg::JPR, "jump_reg");
    issue(isa_pkg::ALU, isa_pkg::JRL, "jump_reg_link");
    issue(isa_pkg::ALU, isa_pkg::WWD, "write_word");
    issue(isa_pkg::ALU, isa_pkg::HLT, "halt");
    issue(4'd12, 6'd0, "illegal_opcode");
    issue(isa_pkg::ALU, 6'd30, "illegal_func");
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      pick_random(op, fn);
      issue(op, fn, "random_mix");
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/control_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit_asserts (
  input logic                 clk,
  input logic                 reset_n,
  input ctrl_pkg::fsm_state_e state,
  input logic                 mem_read,
  input logic                 mem_write,
  input logic                 pc_update,
  input logic                 halt,
  input logic                 reg_write
);

  // one memory access per cycle
  mem_exclusive: assert property (@(posedge clk) disable iff (reset_n)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write high in the same cycle");

  end_goes_to_fetch: assert property (@(posedge clk) disable iff (reset_n)
    pc_update |=> state == ctrl_pkg::S_IF)
    else $error("state after pc_update is not S_IF");

  halt_in_fetch: assert property (@(posedge clk) disable iff (reset_n)
    halt |-> state == ctrl_pkg::S_IF)
    else $error("halt seen outside S_IF");

  write_in_wb: assert property (@(posedge clk) disable iff (reset_n)
    reg_write |-> state == ctrl_pkg::S_WB)
    else $error("reg_write seen outside S_WB");

endmodule

`default_nettype wire

//--- hdl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module control_unit (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [`OPCODE_W-1:0] opcode,
  input  logic [`FUNC_W-1:0]   func_code,
  output logic                 mem_write,
  output logic                 mem_read,
  output logic                 reg_write,
  output logic                 reg_dst,
  output logic                 pc_to_reg,
  output logic                 mem_to_reg,
  output logic                 alu_src_a,
  output logic                 alu_src_b,
  output logic                 alu_op,
  output logic                 pc_store,
  output logic                 branch_dst_store,
  output logic                 branch,
  output logic                 jal,
  output logic                 jalr,
  output logic                 pc_update, // last cycle of instruction
  output logic                 halt,
  output logic                 wwd
);

  ctrl_pkg::instr_class_e instr_class;
  ctrl_pkg::fsm_state_e   state;

  instr_decoder u_decoder (
    .opcode      (opcode),
    .func_code   (func_code),
    .instr_class (instr_class)
  );

  state_sequencer u_sequencer (
    .clk         (clk),
    .reset_n     (reset_n),
    .instr_class (instr_class),
    .state       (state)
  );

  control_signal_gen u_ctrl_gen (
    .state            (state),
    .instr_class      (instr_class),
    .mem_write        (mem_write),
    .mem_read         (mem_read),
    .reg_write        (reg_write),
    .reg_dst          (reg_dst),
    .pc_to_reg        (pc_to_reg),
    .mem_to_reg       (mem_to_reg),
    .alu_src_a        (alu_src_a),
    .alu_src_b        (alu_src_b),
    .alu_op           (alu_op),
    .pc_store         (pc_store),
    .branch_dst_store (branch_dst_store),
    .branch           (branch),
    .jal              (jal),
    .jalr             (jalr),
    .pc_update        (pc_update),
    .halt             (halt),
    .wwd              (wwd)
  );

endmodule

`default_nettype wire

//--- hdl/control_signal_gen.sv
`timescale 1ns/1ps
`default_nettype none

module control_signal_gen (
  input  ctrl_pkg::fsm_state_e   state,
  input  ctrl_pkg::instr_class_e instr_class,
  output logic                   mem_write,
  output logic                   mem_read,
  output logic                   reg_write,
  output logic                   reg_dst,
  output logic                   pc_to_reg,
  output logic                   mem_to_reg,
  output logic                   alu_src_a,
  output logic                   alu_src_b,
  output logic                   alu_op,
  output logic                   pc_store,
  output logic                   branch_dst_store,
  output logic                   branch,
  output logic                   jal,
  output logic                   jalr,
  output logic                   pc_update,
  output logic                   halt,
  output logic                   wwd
);

  logic                 on_path;
  ctrl_pkg::fsm_state_e last_state;
  logic                 alu_cls;
  logic                 mem_cls;
  logic                 past_if;

  // which states the class visits, and where it ends
  always_comb begin
    on_path    = 1'b0;
    last_state = ctrl_pkg::S_IF;
    case (instr_class)
      ctrl_pkg::C_ALU_R,
      ctrl_pkg::C_ALU_I: begin
        on_path    = state inside {ctrl_pkg::S_IF, ctrl_pkg::S_ID, ctrl_pkg::S_EX1,
                                   ctrl_pkg::S_WB};
        last_state = ctrl_pkg::S_WB;
      end
      ctrl_pkg::C_LOAD: begin
        on_path    = state inside {ctrl_pkg::S_IF, ctrl_pkg::S_ID, ctrl_pkg::S_EX1,
                                   ctrl_pkg::S_MEM, ctrl_pkg::S_WB};
        last_state = ctrl_pkg::S_WB;
      end
      ctrl_pkg::C_STORE: begin
        on_path    = state inside {ctrl_pkg::S_IF, ctrl_pkg::S_ID, ctrl_pkg::S_EX1,
                                   ctrl_pkg::S_MEM};
        last_state = ctrl_pkg::S_MEM;
      end
      ctrl_pkg::C_BRANCH: begin
        on_path    = state inside {ctrl_pkg::S_IF, ctrl_pkg::S_ID, ctrl_pkg::S_EX1,
                                   ctrl_pkg::S_EX2};
        last_state = ctrl_pkg::S_EX2;
      end
      ctrl_pkg::C_JMP,
      ctrl_pkg::C_JPR,
      ctrl_pkg::C_WWD: begin
        on_path    = state inside {ctrl_pkg::S_IF, ctrl_pkg::S_ID, ctrl_pkg::S_EX1};
        last_state = ctrl_pkg::S_EX1;
      end
      ctrl_pkg::C_JAL,
      ctrl_pkg::C_JRL: begin
        on_path    = state inside {ctrl_pkg::S_IF, ctrl_pkg::S_ID, ctrl_pkg::S_WB};
        last_state = ctrl_pkg::S_WB;
      end
      default: begin // halt, illegal never leave IF
        on_path    = 1'b0;
        last_state = ctrl_pkg::S_IF;
      end
    endcase
  end

  assign alu_cls = instr_class inside {ctrl_pkg::C_ALU_R, ctrl_pkg::C_ALU_I};
  assign mem_cls = instr_class inside {ctrl_pkg::C_LOAD, ctrl_pkg::C_STORE};
  assign past_if = on_path && (state != ctrl_pkg::S_IF);

  always_comb begin
    mem_write        = 1'b0;
    mem_read         = 1'b0;
    reg_write        = 1'b0;
    reg_dst          = 1'b0;
    pc_to_reg        = 1'b0;
    mem_to_reg       = 1'b0;
    alu_src_a        = 1'b0;
    alu_src_b        = 1'b0;
    alu_op           = 1'b0;
    pc_store         = 1'b0;
    branch_dst_store = 1'b0;
    branch           = 1'b0;
    pc_update        = past_if && (state == last_state);
    halt             = (instr_class == ctrl_pkg::C_HALT);
    jal              = past_if && (instr_class inside {ctrl_pkg::C_JMP, ctrl_pkg::C_JAL});
    jalr             = past_if && (instr_class inside {ctrl_pkg::C_JPR, ctrl_pkg::C_JRL});
    wwd              = past_if && (instr_class == ctrl_pkg::C_WWD);
    if (on_path) begin
      case (state)
        ctrl_pkg::S_ID: begin
          pc_store = !(instr_class inside {ctrl_pkg::C_JMP, ctrl_pkg::C_JAL,
                                           ctrl_pkg::C_JPR});
          branch   = (instr_class == ctrl_pkg::C_BRANCH);
        end
        ctrl_pkg::S_EX1: begin
          alu_src_a        = alu_cls || mem_cls || instr_class == ctrl_pkg::C_BRANCH;
          alu_src_b        = alu_src_a && instr_class != ctrl_pkg::C_ALU_R;
          alu_op           = alu_cls || mem_cls || instr_class == ctrl_pkg::C_JMP;
          branch           = (instr_class == ctrl_pkg::C_BRANCH);
          branch_dst_store = (instr_class == ctrl_pkg::C_BRANCH);
        end
        ctrl_pkg::S_EX2: begin // branch only
          alu_src_a = 1'b1;
          alu_op    = 1'b1;
          branch    = 1'b1;
        end
        ctrl_pkg::S_MEM: begin // load or store only
          alu_src_a = 1'b1;
          alu_src_b = 1'b1;
          alu_op    = 1'b1;
          mem_read  = (instr_class == ctrl_pkg::C_LOAD);
          mem_write = (instr_class == ctrl_pkg::C_STORE);
        end
        ctrl_pkg::S_WB: begin
          reg_write  = 1'b1;
          reg_dst    = instr_class inside {ctrl_pkg::C_ALU_I, ctrl_pkg::C_LOAD};
          mem_to_reg = (instr_class == ctrl_pkg::C_LOAD);
          pc_to_reg  = (instr_class == ctrl_pkg::C_JRL);
          alu_src_a  = alu_cls;
          alu_src_b  = (instr_class == ctrl_pkg::C_ALU_I);
          alu_op     = alu_cls || instr_class == ctrl_pkg::C_LOAD; // result held
        end
        default: begin
          // IF drives nothing beyond halt
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/state_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module state_sequencer (
  input  logic                   clk,
  input  logic                   reset_n,
  input  ctrl_pkg::instr_class_e instr_class,
  output ctrl_pkg::fsm_state_e   state
);

  ctrl_pkg::fsm_state_e next_state;

  always_ff @(posedge clk) begin
    if (reset_n) begin // active high
      state <= ctrl_pkg::S_IF;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = ctrl_pkg::S_IF;
    case (state)
      ctrl_pkg::S_IF: begin
        if (instr_class != ctrl_pkg::C_HALT && instr_class != ctrl_pkg::C_ILLEGAL) begin
          next_state = ctrl_pkg::S_ID;
        end
      end
      ctrl_pkg::S_ID: begin
        case (instr_class)
          ctrl_pkg::C_JAL,
          ctrl_pkg::C_JRL:     next_state = ctrl_pkg::S_WB; // link write only
          ctrl_pkg::C_HALT,
          ctrl_pkg::C_ILLEGAL: next_state = ctrl_pkg::S_IF;
          default:             next_state = ctrl_pkg::S_EX1;
        endcase
      end
      ctrl_pkg::S_EX1: begin
        case (instr_class)
          ctrl_pkg::C_ALU_R,
          ctrl_pkg::C_ALU_I:  next_state = ctrl_pkg::S_WB;
          ctrl_pkg::C_LOAD,
          ctrl_pkg::C_STORE:  next_state = ctrl_pkg::S_MEM;
          ctrl_pkg::C_BRANCH: next_state = ctrl_pkg::S_EX2;
          default:            next_state = ctrl_pkg::S_IF; // jumps, wwd done
        endcase
      end
      ctrl_pkg::S_MEM: begin
        if (instr_class == ctrl_pkg::C_LOAD) begin
          next_state = ctrl_pkg::S_WB;
        end
      end
      // EX2 and WB always end the instruction
      default: next_state = ctrl_pkg::S_IF;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module instr_decoder (
  input  logic [`OPCODE_W-1:0]   opcode,
  input  logic [`FUNC_W-1:0]     func_code,
  output ctrl_pkg::instr_class_e instr_class
);

  always_comb begin
    instr_class = ctrl_pkg::C_ILLEGAL;
    case (isa_pkg::opcode_e'(opcode))
      isa_pkg::BNE,
      isa_pkg::BEQ,
      isa_pkg::BGZ,
      isa_pkg::BLZ: instr_class = ctrl_pkg::C_BRANCH;
      isa_pkg::ADI,
      isa_pkg::ORI,
      isa_pkg::LHI: instr_class = ctrl_pkg::C_ALU_I;
      isa_pkg::LWD: instr_class = ctrl_pkg::C_LOAD;
      isa_pkg::SWD: instr_class = ctrl_pkg::C_STORE;
      isa_pkg::JMP: instr_class = ctrl_pkg::C_JMP;
      isa_pkg::JAL: instr_class = ctrl_pkg::C_JAL;
      isa_pkg::ALU: begin
        case (isa_pkg::func_e'(func_code))
          isa_pkg::ADD,
          isa_pkg::SUB,
          isa_pkg::AND,
          isa_pkg::ORR,
          isa_pkg::NOT,
          isa_pkg::TCP,
          isa_pkg::SHL,
          isa_pkg::SHR: instr_class = ctrl_pkg::C_ALU_R;
          isa_pkg::JPR: instr_class = ctrl_pkg::C_JPR;
          isa_pkg::JRL: instr_class = ctrl_pkg::C_JRL;
          isa_pkg::WWD: instr_class = ctrl_pkg::C_WWD;
          isa_pkg::HLT: instr_class = ctrl_pkg::C_HALT;
          default:      instr_class = ctrl_pkg::C_ILLEGAL; // unassigned func
        endcase
      end
      default: instr_class = ctrl_pkg::C_ILLEGAL; // opcodes 11..14
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/ctrl_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package ctrl_pkg;

  typedef enum logic [`STATE_W-1:0] {
    S_IF  = 0,
    S_ID  = 1,
    S_EX1 = 2,
    S_EX2 = 3, // branch compare
    S_MEM = 4,
    S_WB  = 5
  } fsm_state_e;

  // one state path per instruction class
  typedef enum logic [3:0] {
    C_ALU_R,
    C_ALU_I,
    C_LOAD,
    C_STORE,
    C_BRANCH,
    C_JMP,
    C_JAL,
    C_JPR,
    C_JRL,
    C_WWD,
    C_HALT,
    C_ILLEGAL
  } instr_class_e;

endpackage

`default_nettype wire

//--- hdl/isa_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package isa_pkg;

  // major opcodes in instr[15:12]
  typedef enum logic [`OPCODE_W-1:0] {
    BNE = 0,
    BEQ = 1,
    BGZ = 2,
    BLZ = 3,
    ADI = 4,
    ORI = 5,
    LHI = 6,
    LWD = 7,
    SWD = 8,
    JMP = 9,
    JAL = 10,
    ALU = 15 // r-type ops selected by func_e
  } opcode_e;

  // function codes under opcode ALU
  typedef enum logic [`FUNC_W-1:0] {
    ADD = 0,
    SUB = 1,
    AND = 2,
    ORR = 3,
    NOT = 4,
    TCP = 5, // two's complement
    SHL = 6,
    SHR = 7,
    JPR = 25,
    JRL = 26,
    WWD = 28,
    HLT = 29
  } func_e;

endpackage

`default_nettype wire

//--- hdl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// instruction field widths
`define OPCODE_W 4
`define FUNC_W 6

// controller state register width
`define STATE_W 3

`endif
